//--- flist.f
+incdir+verilog
verilog/redmule_cfg_pkg.sv
verilog/redmule_mem_pkg.sv
verilog/redmule_ctrl.sv
verilog/redmule_scheduler.sv
verilog/redmule_streamer.sv
verilog/redmule_engine.sv
verilog/redmule_top.sv
test/tb_clk_gen.sv
test/tb_redmule_assertions.sv
test/tb_redmule.sv

//--- Bender.yml
package:
  name: redmule_int

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/redmule_cfg_pkg.sv
      - verilog/redmule_mem_pkg.sv
      - verilog/redmule_ctrl.sv
      - verilog/redmule_scheduler.sv
      - verilog/redmule_streamer.sv
      - verilog/redmule_engine.sv
      - verilog/redmule_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clk_gen.sv
      - test/tb_redmule_assertions.sv
      - test/tb_redmule.sv

//--- test/tb_redmule.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE testbench
// Memory model, job table and Z = X*W + Y checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "redmule_defs.svh"

module tb_redmule;

  localparam int MEM_WORDS   = 1024;
  localparam int X_IDX       = 32;
  localparam int W_IDX       = 128;
  localparam int Y_IDX       = 256;
  localparam int Z_IDX       = 384;
  localparam int NUM_JOBS    = 5;
  localparam int JOB_TIMEOUT = 2000;
  localparam int REG_TIMEOUT = 10;

  typedef struct packed {
    logic [3:0]  m;
    logic [2:0]  k;
    logic [31:0] seed;
    logic [7:0]  gnt_pct;
    logic        retrig;
    logic        big;
  } job_t;

  logic clk_i;
  logic arst_n_i;
  logic busy;
  logic evt;
  redmule_cfg_pkg::periph_req_t periph_req;
  redmule_cfg_pkg::periph_rsp_t periph_rsp;
  redmule_mem_pkg::mem_req_t    mem_req;
  redmule_mem_pkg::mem_rsp_t    mem_rsp;
  redmule_mem_pkg::mem_word_t   mem [MEM_WORDS];
  job_t job_table [NUM_JOBS];
  integer gnt_seed = 32'h04c8_3033;
  int gnt_pct = 100;
  int evt_count = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    ( clk_i    ),
    .arst_n_o ( arst_n_i )
  );

  redmule_top u_redmule_top (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .periph_req_i ( periph_req ),
    .periph_rsp_o ( periph_rsp ),
    .mem_req_o    ( mem_req    ),
    .mem_rsp_i    ( mem_rsp    ),
    .busy_o       ( busy       ),
    .evt_o        ( evt        )
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_elem(input redmule_mem_pkg::elem_t got,
                            input redmule_mem_pkg::elem_t exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("error: time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_reg(input redmule_cfg_pkg::reg_word_t got,
                           input redmule_cfg_pkg::reg_word_t exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("error: time %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("error: time %0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic next_cycle;
    @(posedge clk_i);
    #2;
  endtask

  // Background pattern, distinct for every word address
  function automatic redmule_mem_pkg::mem_word_t fill_word(input int idx);
    logic [15:0] a;
    a = idx[15:0];
    fill_word[0] = a ^ 16'h5a5a;
    fill_word[1] = ~a;
    fill_word[2] = {a[7:0], a[15:8]};
    fill_word[3] = a + 16'h3c3c;
  endfunction

  // Small values stay in 8 bits, large ones sit near the 16-bit limits
  function automatic redmule_mem_pkg::elem_t gen_elem(inout integer seed, input logic big);
    logic [31:0] r;
    r = $random(seed);
    if (big) begin
      gen_elem = {4'b0111, r[11:0]} ^ {16{r[15]}};
    end else begin
      gen_elem = $signed(r[7:0]);
    end
  endfunction

  // Memory model, samples mid-cycle and answers after the next edge
  always begin : mem_model
    logic                       grant;
    logic                       we;
    logic [`REDMULE_ADDR_W-1:0] addr;
    redmule_mem_pkg::mem_word_t wdata;
    @(negedge clk_i);
    grant = arst_n_i && mem_req.req && mem_rsp.gnt;
    we    = mem_req.we;
    addr  = mem_req.addr;
    wdata = mem_req.wdata;
    @(posedge clk_i);
    #2;
    mem_rsp.r_valid = 1'b0;
    if (grant) begin
      if (addr[2:0] != 3'b0 || addr >= MEM_WORDS * 8) begin
        abort_run($sformatf("memory access to address %h is outside the model", addr));
      end
      if (we) begin
        mem[addr >> 3] = wdata;
      end else begin
        mem_rsp.r_valid = 1'b1;
        mem_rsp.r_data  = mem[addr >> 3];
      end
    end
    mem_rsp.gnt = ($unsigned($random(gnt_seed)) % 100) < gnt_pct;
  end

  always @(negedge clk_i) begin
    if (arst_n_i && evt) begin
      evt_count++;
    end
  end

  // Stop as soon as a bound protocol assertion has failed
  always @(negedge clk_i) begin
    if (u_redmule_top.u_assertions.fail_count != 0) begin
      abort_run("a protocol assertion failed during the run");
    end
  end

  task automatic write_register(input logic [`REDMULE_OFFS_W-1:0] offs,
                                input redmule_cfg_pkg::reg_word_t data);
    periph_req.req   = 1'b1;
    periph_req.we    = 1'b1;
    periph_req.addr  = offs;
    periph_req.wdata = data;
    next_cycle();
    periph_req.req = 1'b0;
    periph_req.we  = 1'b0;
  endtask

  task automatic read_register(input logic [`REDMULE_OFFS_W-1:0] offs,
                               output redmule_cfg_pkg::reg_word_t data);
    int cycles;
    cycles = 0;
    periph_req.req   = 1'b1;
    periph_req.we    = 1'b0;
    periph_req.addr  = offs;
    periph_req.wdata = '0;
    next_cycle();
    periph_req.req = 1'b0;
    @(negedge clk_i);
    while (!periph_rsp.r_valid) begin
      cycles++;
      if (cycles > REG_TIMEOUT) begin
        abort_run("timeout waiting for a register read response");
      end
      @(negedge clk_i);
    end
    data = periph_rsp.r_data;
    next_cycle();
  endtask

  // Busy must hold until the event, then be low with it
  task automatic wait_job_end;
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!evt) begin
      check_flag(busy, 1'b1, "busy_o");
      cycles++;
      if (cycles > JOB_TIMEOUT) begin
        abort_run("timeout waiting for evt_o at the end of a job");
      end
      @(negedge clk_i);
    end
    check_flag(busy, 1'b0, "busy_o");
    next_cycle();
  endtask

  task automatic run_job(input job_t job);
    redmule_mem_pkg::elem_t     x [`REDMULE_MAX_M][`REDMULE_LANES];
    redmule_mem_pkg::elem_t     w [`REDMULE_LANES][`REDMULE_LANES];
    redmule_mem_pkg::elem_t     y [`REDMULE_MAX_M][`REDMULE_LANES];
    redmule_cfg_pkg::reg_word_t rd;
    redmule_cfg_pkg::reg_word_t vals [6];
    logic [`REDMULE_OFFS_W-1:0] offs [6];
    integer fill_seed;
    int sum;
    int evt_before;
    fill_seed = job.seed;
    gnt_pct   = job.gnt_pct;
    for (int m = 0; m < job.m; m++) begin
      mem[Z_IDX + m] = fill_word(Z_IDX + m);
      for (int l = 0; l < `REDMULE_LANES; l++) begin
        x[m][l] = gen_elem(fill_seed, job.big);
        y[m][l] = gen_elem(fill_seed, job.big);
        mem[X_IDX + m][l] = x[m][l];
        mem[Y_IDX + m][l] = y[m][l];
      end
    end
    for (int k = 0; k < job.k; k++) begin
      for (int l = 0; l < `REDMULE_LANES; l++) begin
        w[k][l] = gen_elem(fill_seed, job.big);
        mem[W_IDX + k][l] = w[k][l];
      end
    end
    offs = '{`REDMULE_REG_X_ADDR, `REDMULE_REG_W_ADDR, `REDMULE_REG_Y_ADDR,
             `REDMULE_REG_Z_ADDR, `REDMULE_REG_M_SIZE, `REDMULE_REG_K_SIZE};
    vals = '{X_IDX * 8, W_IDX * 8, Y_IDX * 8, Z_IDX * 8, 32'(job.m), 32'(job.k)};
    for (int i = 0; i < 6; i++) begin
      write_register(offs[i], vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      read_register(offs[i], rd);
      check_reg(rd, vals[i], $sformatf("register 0x%02h", offs[i]));
    end
    read_register(`REDMULE_REG_STATUS, rd);
    check_reg(rd, 32'd0, "status");

    evt_before = evt_count;
    write_register(`REDMULE_REG_TRIGGER, 32'd1);
    read_register(`REDMULE_REG_STATUS, rd);
    check_reg(rd, 32'd1, "status");
    if (job.retrig) begin
      write_register(`REDMULE_REG_TRIGGER, 32'd1);
    end
    wait_job_end();
    repeat (8) next_cycle();
    if (evt_count - evt_before != 1) begin
      abort_run($sformatf("evt_o pulsed %0d times for one job", evt_count - evt_before));
    end

    // Reference result, wrapped to 16 bits
    for (int m = 0; m < job.m; m++) begin
      for (int n = 0; n < `REDMULE_LANES; n++) begin
        sum = y[m][n];
        for (int k = 0; k < job.k; k++) begin
          sum = sum + x[m][k] * w[k][n];
        end
        check_elem(mem[Z_IDX + m][n], sum[15:0], $sformatf("z[%0d][%0d]", m, n));
      end
    end
  endtask

  initial begin
    int cycles;
    periph_req = '0;
    mem_rsp    = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    // M, K, fill seed, gnt percent, retrigger, large values
    job_table[0] = '{4'd2, 3'd4, 32'h0000_1111, 8'd100, 1'b0, 1'b0};
    job_table[1] = '{4'd2, 3'd4, 32'h0000_1111, 8'd40, 1'b0, 1'b0};
    job_table[2] = '{4'd3, 3'd3, 32'h0000_2a2a, 8'd70, 1'b1, 1'b0};
    job_table[3] = '{4'd1, 3'd1, 32'h0000_3b3b, 8'd100, 1'b0, 1'b1};
    job_table[4] = '{4'd5, 3'd2, 32'h0000_4c4c, 8'd55, 1'b1, 1'b1};

    cycles = 0;
    while (!arst_n_i) begin
      cycles++;
      if (cycles > 20) begin
        abort_run("timeout waiting for reset release");
      end
      @(posedge clk_i);
    end
    next_cycle();
    check_flag(busy, 1'b0, "busy_o");
    check_flag(evt, 1'b0, "evt_o");
    check_flag(mem_req.req, 1'b0, "mem_req_o.req");
    check_flag(periph_rsp.r_valid, 1'b0, "periph_rsp_o.r_valid");

    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(job_table[j]);
    end

    if (u_redmule_top.u_assertions.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run("a protocol assertion failed during the run");
    end
  end

endmodule

//--- test/tb_redmule_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE protocol assertions
// Memory handshake and done event rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_redmule_assertions (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input redmule_mem_pkg::mem_req_t mem_req_i,
  input redmule_mem_pkg::mem_rsp_t mem_rsp_i,
  input logic                      busy_i,
  input logic                      evt_i
);

  int fail_count = 0;

  // A waiting request must not change
  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i.req && !mem_rsp_i.gnt |=> mem_req_i.req && $stable(mem_req_i.addr)
      && $stable(mem_req_i.we) && $stable(mem_req_i.wdata))
  else begin
    $error("memory request changed while waiting for gnt");
    fail_count++;
  end

  a_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rsp_i.r_valid == $past(mem_req_i.req && mem_rsp_i.gnt && !mem_req_i.we))
  else begin
    $error("r_valid does not follow a granted read by one cycle");
    fail_count++;
  end

  a_evt_width: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_i |=> !evt_i)
  else begin
    $error("evt_o wider than one cycle");
    fail_count++;
  end

  // Event and falling busy go together in both directions
  a_evt_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_i == $fell(busy_i))
  else begin
    $error("evt_o does not coincide with busy_o falling");
    fail_count++;
  end

endmodule

bind redmule_top tb_redmule_assertions u_assertions (
  .clk_i     ( clk_i     ),
  .arst_n_i  ( arst_n_i  ),
  .mem_req_i ( mem_req_o ),
  .mem_rsp_i ( mem_rsp_i ),
  .busy_i    ( busy_o    ),
  .evt_i     ( evt_o     )
);

//--- test/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// 20 ns clock, reset held low for 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release a little after the edge, like every other input
  initial begin
    arst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

//--- verilog/redmule_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE top level
// Integer Z = X*W + Y accelerator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "redmule_defs.svh"

module redmule_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  redmule_cfg_pkg::periph_req_t periph_req_i,
  output redmule_cfg_pkg::periph_rsp_t periph_rsp_o,
  output redmule_mem_pkg::mem_req_t    mem_req_o,
  input  redmule_mem_pkg::mem_rsp_t    mem_rsp_i,
  output logic                         busy_o,
  output logic                         evt_o
);

  redmule_cfg_pkg::job_cfg_t   cfg;
  redmule_mem_pkg::access_op_e acc_op;
  redmule_mem_pkg::access_op_e load_op;
  redmule_mem_pkg::mem_word_t  load_data;
  redmule_mem_pkg::mem_word_t  z_row;
  logic [`REDMULE_ROW_W-1:0]   acc_row;
  logic [`REDMULE_KIDX_W-1:0]  mac_k;
  logic start;
  logic done;
  logic acc_cmd;
  logic acc_busy;
  logic acc_done;
  logic load_valid;
  logic mac_step;

  redmule_ctrl u_ctrl (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .done_i       ( done         ),
    .start_o      ( start        ),
    .cfg_o        ( cfg          ),
    .busy_o       ( busy_o       ),
    .evt_o        ( evt_o        )
  );

  redmule_scheduler u_scheduler (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .start_i    ( start    ),
    .cfg_i      ( cfg      ),
    .acc_busy_i ( acc_busy ),
    .acc_done_i ( acc_done ),
    .acc_cmd_o  ( acc_cmd  ),
    .acc_op_o   ( acc_op   ),
    .acc_row_o  ( acc_row  ),
    .mac_step_o ( mac_step ),
    .mac_k_o    ( mac_k    ),
    .done_o     ( done     )
  );

  redmule_streamer u_streamer (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .cfg_i        ( cfg        ),
    .acc_cmd_i    ( acc_cmd    ),
    .acc_op_i     ( acc_op     ),
    .acc_row_i    ( acc_row    ),
    .acc_busy_o   ( acc_busy   ),
    .acc_done_o   ( acc_done   ),
    .z_row_i      ( z_row      ),
    .mem_req_o    ( mem_req_o  ),
    .mem_rsp_i    ( mem_rsp_i  ),
    .load_op_o    ( load_op    ),
    .load_valid_o ( load_valid ),
    .load_data_o  ( load_data  )
  );

  // W row index is k, so only the low bits of the row matter here
  redmule_engine u_engine (
    .clk_i        ( clk_i                          ),
    .arst_n_i     ( arst_n_i                       ),
    .load_valid_i ( load_valid                     ),
    .load_op_i    ( load_op                        ),
    .load_row_i   ( acc_row[`REDMULE_KIDX_W-1:0]   ),
    .load_data_i  ( load_data                      ),
    .mac_step_i   ( mac_step                       ),
    .mac_k_i      ( mac_k                          ),
    .z_row_o      ( z_row                          )
  );

endmodule

//--- verilog/redmule_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE engine
// W buffer, X row and a row of integer MAC lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "redmule_defs.svh"

module redmule_engine (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        load_valid_i,
  input  redmule_mem_pkg::access_op_e load_op_i,
  input  logic [`REDMULE_KIDX_W-1:0]  load_row_i,
  input  redmule_mem_pkg::mem_word_t  load_data_i,
  input  logic                        mac_step_i,
  input  logic [`REDMULE_KIDX_W-1:0]  mac_k_i,
  output redmule_mem_pkg::mem_word_t  z_row_o
);

  redmule_mem_pkg::mem_word_t w_buf_q [`REDMULE_LANES];
  redmule_mem_pkg::mem_word_t x_row_q;
  redmule_mem_pkg::mem_word_t w_k;
  redmule_mem_pkg::elem_t     x_k;
  redmule_mem_pkg::elem_t     acc_q [`REDMULE_LANES];
  logic load_w;
  logic load_x;
  logic load_y;

  assign load_w = load_valid_i && (load_op_i == redmule_mem_pkg::OP_LOAD_W);
  assign load_x = load_valid_i && (load_op_i == redmule_mem_pkg::OP_LOAD_X);
  assign load_y = load_valid_i && (load_op_i == redmule_mem_pkg::OP_LOAD_Y);

  always_ff @(posedge clk_i) begin
    if (load_w) begin
      w_buf_q[load_row_i] <= load_data_i;
    end
    if (load_x) begin
      x_row_q <= load_data_i;
    end
  end

  // X[k] is broadcast to every lane, lane n takes W[k][n]
  assign x_k = x_row_q[mac_k_i];
  assign w_k = w_buf_q[mac_k_i];

  for (genvar n = 0; n < `REDMULE_LANES; n++) begin : gen_lane
    // Y preloads the accumulator, sums wrap at 16 bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        acc_q[n] <= '0;
      end else if (load_y) begin
        acc_q[n] <= load_data_i[n];
      end else if (mac_step_i) begin
        acc_q[n] <= acc_q[n] + x_k * w_k[n];
      end
    end

    assign z_row_o[n] = acc_q[n];
  end

endmodule

//--- verilog/redmule_streamer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE streamer
// Address generation and memory port handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "redmule_defs.svh"

module redmule_streamer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  redmule_cfg_pkg::job_cfg_t   cfg_i,
  input  logic                        acc_cmd_i,
  input  redmule_mem_pkg::access_op_e acc_op_i,
  input  logic [`REDMULE_ROW_W-1:0]   acc_row_i,
  output logic                        acc_busy_o,
  output logic                        acc_done_o,
  input  redmule_mem_pkg::mem_word_t  z_row_i,
  output redmule_mem_pkg::mem_req_t   mem_req_o,
  input  redmule_mem_pkg::mem_rsp_t   mem_rsp_i,
  output redmule_mem_pkg::access_op_e load_op_o,
  output logic                        load_valid_o,
  output redmule_mem_pkg::mem_word_t  load_data_o
);

  redmule_mem_pkg::access_op_e op_q;
  redmule_mem_pkg::mem_word_t  wdata_q;
  logic [`REDMULE_ADDR_W-1:0]  base;
  logic [`REDMULE_ADDR_W-1:0]  addr_q;
  logic req_q;
  logic wait_q;
  logic is_store;
  logic granted;

  assign is_store = (op_q == redmule_mem_pkg::OP_STORE_Z);
  assign granted  = req_q && mem_rsp_i.gnt;

  always_comb begin
    case (acc_op_i)
      redmule_mem_pkg::OP_LOAD_W: base = cfg_i.w_addr;
      redmule_mem_pkg::OP_LOAD_X: base = cfg_i.x_addr;
      redmule_mem_pkg::OP_LOAD_Y: base = cfg_i.y_addr;
      default:                    base = cfg_i.z_addr;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      op_q   <= redmule_mem_pkg::OP_LOAD_W;
    end else begin
      if (acc_cmd_i) begin
        req_q <= 1'b1;
        op_q  <= acc_op_i;
      end else if (granted) begin
        req_q <= 1'b0;
      end
      // Loads wait one more cycle for the read data
      if (granted && !is_store) begin
        wait_q <= 1'b1;
      end else if (mem_rsp_i.r_valid) begin
        wait_q <= 1'b0;
      end
    end
  end

  // One 64-bit word per row, so rows are 8 bytes apart
  always_ff @(posedge clk_i) begin
    if (acc_cmd_i) begin
      addr_q  <= base + (`REDMULE_ADDR_W'(acc_row_i) << 3);
      wdata_q <= z_row_i;
    end
  end

  assign mem_req_o.req   = req_q;
  assign mem_req_o.we    = req_q && is_store;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = wdata_q;

  assign load_valid_o = wait_q && mem_rsp_i.r_valid;
  assign load_op_o    = op_q;
  assign load_data_o  = mem_rsp_i.r_data;

  assign acc_busy_o = req_q || wait_q;
  assign acc_done_o = (granted && is_store) || load_valid_o;

endmodule

//--- verilog/redmule_scheduler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE job scheduler
// Orders W, X, Y loads, MAC steps and Z stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "redmule_defs.svh"

module redmule_scheduler (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           start_i,
  input  redmule_cfg_pkg::job_cfg_t      cfg_i,
  input  logic                           acc_busy_i,
  input  logic                           acc_done_i,
  output logic                           acc_cmd_o,
  output redmule_mem_pkg::access_op_e    acc_op_o,
  output logic [`REDMULE_ROW_W-1:0]      acc_row_o,
  output logic                           mac_step_o,
  output logic [`REDMULE_KIDX_W-1:0]     mac_k_o,
  output logic                           done_o
);

  redmule_cfg_pkg::sched_state_e state_q;
  logic [`REDMULE_ROW_W-1:0]  row_q;
  logic [`REDMULE_KIDX_W-1:0] k_q;
  logic acc_pend_q;
  logic in_access;
  logic k_last;
  logic m_last;

  assign k_last = ({1'b0, k_q} == cfg_i.k_size - 1'b1);
  assign m_last = (row_q == cfg_i.m_size - 1'b1);

  assign in_access = state_q inside {redmule_cfg_pkg::LOAD_W, redmule_cfg_pkg::LOAD_X,
                                     redmule_cfg_pkg::LOAD_Y, redmule_cfg_pkg::STORE_Z};

  // One access at a time, held back until the streamer is free
  assign acc_cmd_o = in_access && !acc_pend_q && !acc_busy_i;

  always_comb begin
    case (state_q)
      redmule_cfg_pkg::LOAD_W:  acc_op_o = redmule_mem_pkg::OP_LOAD_W;
      redmule_cfg_pkg::LOAD_Y:  acc_op_o = redmule_mem_pkg::OP_LOAD_Y;
      redmule_cfg_pkg::STORE_Z: acc_op_o = redmule_mem_pkg::OP_STORE_Z;
      default:                  acc_op_o = redmule_mem_pkg::OP_LOAD_X;
    endcase
  end

  // W rows are indexed by k, everything else by the output row
  assign acc_row_o  = (state_q == redmule_cfg_pkg::LOAD_W) ?
                      {{(`REDMULE_ROW_W - `REDMULE_KIDX_W){1'b0}}, k_q} : row_q;
  assign mac_step_o = (state_q == redmule_cfg_pkg::COMPUTE);
  assign mac_k_o    = k_q;
  assign done_o     = (state_q == redmule_cfg_pkg::DONE);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= redmule_cfg_pkg::IDLE;
      row_q      <= '0;
      k_q        <= '0;
      acc_pend_q <= 1'b0;
    end else begin
      if (acc_cmd_o) begin
        acc_pend_q <= 1'b1;
      end else if (acc_done_i) begin
        acc_pend_q <= 1'b0;
      end
      case (state_q)
        redmule_cfg_pkg::IDLE: begin
          if (start_i) begin
            row_q   <= '0;
            k_q     <= '0;
            state_q <= redmule_cfg_pkg::LOAD_W;
          end
        end
        redmule_cfg_pkg::LOAD_W: begin
          if (acc_done_i) begin
            if (k_last) begin
              k_q     <= '0;
              state_q <= redmule_cfg_pkg::LOAD_X;
            end else begin
              k_q <= k_q + 1'b1;
            end
          end
        end
        redmule_cfg_pkg::LOAD_X: begin
          if (acc_done_i) state_q <= redmule_cfg_pkg::LOAD_Y;
        end
        redmule_cfg_pkg::LOAD_Y: begin
          if (acc_done_i) state_q <= redmule_cfg_pkg::COMPUTE;
        end
        // One MAC step per cycle over k
        redmule_cfg_pkg::COMPUTE: begin
          if (k_last) begin
            k_q     <= '0;
            state_q <= redmule_cfg_pkg::STORE_Z;
          end else begin
            k_q <= k_q + 1'b1;
          end
        end
        redmule_cfg_pkg::STORE_Z: begin
          if (acc_done_i) begin
            if (m_last) begin
              state_q <= redmule_cfg_pkg::DONE;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= redmule_cfg_pkg::LOAD_X;
            end
          end
        end
        default: state_q <= redmule_cfg_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- verilog/redmule_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE controller
// Register file, job trigger, busy and done event
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "redmule_defs.svh"

module redmule_ctrl (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  redmule_cfg_pkg::periph_req_t periph_req_i,
  output redmule_cfg_pkg::periph_rsp_t periph_rsp_o,
  input  logic                         done_i,
  output logic                         start_o,
  output redmule_cfg_pkg::job_cfg_t    cfg_o,
  output logic                         busy_o,
  output logic                         evt_o
);

  redmule_cfg_pkg::job_cfg_t  cfg_q;
  redmule_cfg_pkg::reg_word_t rdata_d;
  redmule_cfg_pkg::reg_word_t rdata_q;
  logic write_en;
  logic read_en;
  logic busy_q;
  logic evt_q;
  logic rvalid_q;

  assign write_en = periph_req_i.req && periph_req_i.we;
  assign read_en  = periph_req_i.req && !periph_req_i.we;

  // Trigger only counts while no job is running
  assign start_o = write_en && (periph_req_i.addr == `REDMULE_REG_TRIGGER) && !busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (write_en) begin
      case (periph_req_i.addr)
        `REDMULE_REG_X_ADDR: cfg_q.x_addr <= periph_req_i.wdata;
        `REDMULE_REG_W_ADDR: cfg_q.w_addr <= periph_req_i.wdata;
        `REDMULE_REG_Y_ADDR: cfg_q.y_addr <= periph_req_i.wdata;
        `REDMULE_REG_Z_ADDR: cfg_q.z_addr <= periph_req_i.wdata;
        `REDMULE_REG_M_SIZE: cfg_q.m_size <= periph_req_i.wdata[`REDMULE_ROW_W-1:0];
        `REDMULE_REG_K_SIZE: cfg_q.k_size <= periph_req_i.wdata[`REDMULE_KIDX_W:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (periph_req_i.addr)
      `REDMULE_REG_X_ADDR: rdata_d = cfg_q.x_addr;
      `REDMULE_REG_W_ADDR: rdata_d = cfg_q.w_addr;
      `REDMULE_REG_Y_ADDR: rdata_d = cfg_q.y_addr;
      `REDMULE_REG_Z_ADDR: rdata_d = cfg_q.z_addr;
      `REDMULE_REG_M_SIZE: rdata_d = redmule_cfg_pkg::reg_word_t'(cfg_q.m_size);
      `REDMULE_REG_K_SIZE: rdata_d = redmule_cfg_pkg::reg_word_t'(cfg_q.k_size);
      `REDMULE_REG_STATUS: rdata_d = redmule_cfg_pkg::reg_word_t'(busy_q);
      default:             rdata_d = '0;
    endcase
  end

  // Busy rises after the trigger and drops with the event
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q   <= 1'b0;
      evt_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (start_o) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      evt_q    <= done_i && busy_q;
      rvalid_q <= read_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign periph_rsp_o.r_valid = rvalid_q;
  assign periph_rsp_o.r_data  = rdata_q;
  assign cfg_o  = cfg_q;
  assign busy_o = busy_q;
  assign evt_o  = evt_q;

endmodule

//--- verilog/redmule_mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE memory side types
// Elements, words and the shared memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "redmule_defs.svh"

package redmule_mem_pkg;

  typedef logic signed [`REDMULE_ELEM_W-1:0] elem_t;

  // Lane 0 sits in the low bits
  typedef elem_t [`REDMULE_WORD_W/`REDMULE_ELEM_W-1:0] mem_word_t;

  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`REDMULE_ADDR_W-1:0] addr;
    mem_word_t                  wdata;
  } mem_req_t;

  typedef struct packed {
    logic      gnt;
    logic      r_valid;
    mem_word_t r_data;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    OP_LOAD_W,
    OP_LOAD_X,
    OP_LOAD_Y,
    OP_STORE_Z
  } access_op_e;

endpackage

//--- verilog/redmule_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE configuration types
// Peripheral port, job setup and scheduler states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "redmule_defs.svh"

package redmule_cfg_pkg;

  typedef logic [`REDMULE_REG_W-1:0] reg_word_t;

  // Register port request, no grant needed
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`REDMULE_OFFS_W-1:0] addr;
    reg_word_t                  wdata;
  } periph_req_t;

  typedef struct packed {
    logic      r_valid;
    reg_word_t r_data;
  } periph_rsp_t;

  // One job as programmed through the register file
  typedef struct packed {
    logic [`REDMULE_ADDR_W-1:0]   x_addr;
    logic [`REDMULE_ADDR_W-1:0]   w_addr;
    logic [`REDMULE_ADDR_W-1:0]   y_addr;
    logic [`REDMULE_ADDR_W-1:0]   z_addr;
    logic [`REDMULE_ROW_W-1:0]    m_size;
    logic [`REDMULE_KIDX_W:0]     k_size;
  } job_cfg_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_W,
    LOAD_X,
    LOAD_Y,
    COMPUTE,
    STORE_Z,
    DONE
  } sched_state_e;

endpackage

//--- verilog/redmule_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RedMulE shared parameters
// Lane count, widths, register map and limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef REDMULE_DEFS_SVH
`define REDMULE_DEFS_SVH

`define REDMULE_LANES       4
`define REDMULE_ELEM_W      16
`define REDMULE_WORD_W      64
`define REDMULE_ADDR_W      32
`define REDMULE_REG_W       32
`define REDMULE_OFFS_W      8
`define REDMULE_MAX_M       15

// Index widths derived from the limits
`define REDMULE_ROW_W       $clog2(`REDMULE_MAX_M + 1)
`define REDMULE_KIDX_W      $clog2(`REDMULE_LANES)

// Peripheral register offsets in bytes
`define REDMULE_REG_X_ADDR  8'h00
`define REDMULE_REG_W_ADDR  8'h04
`define REDMULE_REG_Y_ADDR  8'h08
`define REDMULE_REG_Z_ADDR  8'h0C
`define REDMULE_REG_M_SIZE  8'h10
`define REDMULE_REG_K_SIZE  8'h14
`define REDMULE_REG_TRIGGER 8'h54
`define REDMULE_REG_STATUS  8'h58

`endif
